// ==== files.f ====
rtl/router_pkg.sv
rtl/sw_alloc_if.sv
rtl/input_port_ctrl.sv
rtl/output_arbiter.sv
rtl/router_arbiter.sv
verification/tb_clkgen.sv
verification/tb_router_arbiter.sv

// ==== rtl/input_port_ctrl.sv ====
`timescale 1ns/1ns

module input_port_ctrl import router_pkg::*; #(
	parameter int PORT_ID = 0
) (
	input  logic  clk,
	input  logic  arst_n_i,
	input  addr_t yx_pos_i,
	input  logic  empty_i,
	input  addr_t header_addr_i,
	output logic  read_o,
	output port_t route_o,
	sw_alloc_if.requester alloc
);

	// YX routing, the row is settled before the column
	function automatic port_t yx_route(input addr_t dest_addr, input addr_t own_addr);
		logic [COORD_W-1:0] dest_y;
		logic [COORD_W-1:0] dest_x;
		logic [COORD_W-1:0] own_y;
		logic [COORD_W-1:0] own_x;
		port_t hop;
		dest_y = dest_addr[ADDR_W-1:COORD_W];
		dest_x = dest_addr[COORD_W-1:0];
		own_y = own_addr[ADDR_W-1:COORD_W];
		own_x = own_addr[COORD_W-1:0];
		if (dest_y > own_y) begin
			hop = S;
		end else if (dest_y < own_y) begin
			hop = N;
		end else if (dest_x > own_x) begin
			hop = E;
		end else if (dest_x < own_x) begin
			hop = W;
		end else begin
			// Arrived, eject to the local core
			hop = L;
		end
		return hop;
	endfunction

	logic      busy;
	port_t     next_hop;
	port_t     yx_hop;
	flit_cnt_t flit_cnt;
	logic      head_load;
	logic      tail_flit;
	logic      pkt_done;

	// Route of the head flit now at the buffer output
	assign yx_hop = yx_route(header_addr_i, yx_pos_i);

	// Idle input with a head flit waiting
	assign head_load = !busy && !empty_i;

	// At most one output grants this input, since dest names one output
	always_comb begin
		read_o = 1'b0;
		for (int o = 0; o < NUM_PORTS; o++) begin
			read_o = read_o | alloc.gnt[o][PORT_ID];
		end
	end

	assign tail_flit = busy && (flit_cnt == LAST_FLIT);
	assign pkt_done = read_o && tail_flit;

	// Next-hop register, held for the whole packet
	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			busy <= 1'b0;
			next_hop <= N;
		end else if (head_load) begin
			busy <= 1'b1;
			next_hop <= yx_hop;
		end else if (pkt_done) begin
			// Next head is taken one edge later
			busy <= 1'b0;
		end
	end

	// Packet tracker
	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			flit_cnt <= '0;
		end else if (pkt_done) begin
			flit_cnt <= '0;
		end else if (read_o) begin
			flit_cnt <= flit_cnt + 1'b1;
		end
	end

	// Demux select follows the held route
	assign route_o = next_hop;

	// Requests towards the output arbiters
	assign alloc.req[PORT_ID] = busy;
	assign alloc.rdy[PORT_ID] = busy && !empty_i;
	assign alloc.dest[PORT_ID] = next_hop;
	assign alloc.last[PORT_ID] = tail_flit;

endmodule

// ==== rtl/output_arbiter.sv ====
`timescale 1ns/1ns

module output_arbiter import router_pkg::*; #(
	parameter int PORT_ID = 0
) (
	input  logic  clk,
	input  logic  arst_n_i,
	input  logic  credit_i,
	output logic  send_o,
	output port_t mux_sel_o,
	sw_alloc_if.allocator alloc
);

	// This output as a port value, compared against each input's dest
	localparam port_t OWN_PORT = port_t'(PORT_ID);

	logic                 locked;
	port_t                owner;
	port_t                rr_ptr;
	credit_t              credit;
	logic                 found;
	port_t                winner;
	logic                 owner_ok;
	logic                 pkt_end;
	logic [NUM_PORTS-1:0] grant;

	// Round-robin search, starting just after the previous winner
	always_comb begin
		int idx;
		found = 1'b0;
		winner = N;
		for (int k = 1; k <= NUM_PORTS; k++) begin
			idx = (int'(rr_ptr) + k) % NUM_PORTS;
			if (!found && alloc.req[idx] && (alloc.dest[idx] == OWN_PORT)) begin
				found = 1'b1;
				winner = port_t'(idx);
			end
		end
	end

	// Owner has a flit and the downstream buffer has room
	assign owner_ok = locked && alloc.rdy[owner] && (credit != '0);

	// Tail flit leaves, the packet lock ends
	assign pkt_end = owner_ok && alloc.last[owner];

	// One-hot grant to the owner
	always_comb begin
		grant = '0;
		if (owner_ok) begin
			grant[owner] = 1'b1;
		end
	end

	assign alloc.gnt[PORT_ID] = grant;

	// Packet lock and round-robin pointer
	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			locked <= 1'b0;
			owner <= N;
			// First search after reset starts at N
			rr_ptr <= L;
		end else if (!locked) begin
			if (found) begin
				locked <= 1'b1;
				owner <= winner;
			end
		end else if (pkt_end) begin
			locked <= 1'b0;
			rr_ptr <= owner;
		end
	end

	// Credit counter
	// A send and a returned credit in one cycle cancel out
	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			credit <= CREDIT_FULL;
		end else begin
			case ({owner_ok, credit_i})
				2'b10: begin
					credit <= credit - 1'b1;
				end
				2'b01: begin
					credit <= credit + 1'b1;
				end
				default: begin
					credit <= credit;
				end
			endcase
		end
	end

	// Crossbar select and flit strobe for this output
	assign mux_sel_o = owner;
	assign send_o = owner_ok;

endmodule

// ==== rtl/router_arbiter.sv ====
`timescale 1ns/1ns

module router_arbiter import router_pkg::*; (
	input  logic                 clk,
	input  logic                 arst_n_i,

	// Own position in the mesh
	input  addr_t                yx_pos_i,

	// Input buffer status and head flit address
	input  logic [NUM_PORTS-1:0] empty_i,
	input  addr_t                header_addr_i [NUM_PORTS],

	// Credit returns from the downstream routers
	input  logic [NUM_PORTS-1:0] credit_i,

	// Input buffer read strobes and demux selects
	output logic [NUM_PORTS-1:0] read_o,
	output port_t                route_o [NUM_PORTS],

	// Crossbar selects and flit strobes per output
	output port_t                mux_sel_o [NUM_PORTS],
	output logic [NUM_PORTS-1:0] send_o
);

	// Requests and grants between all inputs and all outputs
	sw_alloc_if alloc_if ();

	// Route computation and packet tracking per input
	for (genvar i = 0; i < NUM_PORTS; i++) begin : g_input
		input_port_ctrl #(
			.PORT_ID (i)
		) u_input_port_ctrl (
			.clk           (clk),
			.arst_n_i      (arst_n_i),
			.yx_pos_i      (yx_pos_i),
			.empty_i       (empty_i[i]),
			.header_addr_i (header_addr_i[i]),
			.read_o        (read_o[i]),
			.route_o       (route_o[i]),
			.alloc         (alloc_if.requester)
		);
	end

	// Round-robin arbitration and credits per output
	for (genvar o = 0; o < NUM_PORTS; o++) begin : g_output
		output_arbiter #(
			.PORT_ID (o)
		) u_output_arbiter (
			.clk       (clk),
			.arst_n_i  (arst_n_i),
			.credit_i  (credit_i[o]),
			.send_o    (send_o[o]),
			.mux_sel_o (mux_sel_o[o]),
			.alloc     (alloc_if.allocator)
		);
	end

endmodule

// ==== rtl/router_pkg.sv ====
package router_pkg;

	// Port count and index width
	localparam int NUM_PORTS = 5;
	localparam int PORT_W = 3;

	// Port index, also used as demux and crossbar select
	typedef enum logic [PORT_W-1:0] {
		N = 3'd0,
		S = 3'd1,
		W = 3'd2,
		E = 3'd3,
		L = 3'd4
	} port_t;

	// Mesh address, y in the upper half and x in the lower half
	localparam int COORD_W = 4;
	localparam int ADDR_W = 2 * COORD_W;

	typedef logic [ADDR_W-1:0] addr_t;

	// Fixed packet length, head flit first
	localparam int PKT_FLITS = 4;
	localparam int FLIT_CNT_W = $clog2(PKT_FLITS);

	typedef logic [FLIT_CNT_W-1:0] flit_cnt_t;

	// Index of the tail flit within a packet
	localparam flit_cnt_t LAST_FLIT = flit_cnt_t'(PKT_FLITS - 1);

	// Downstream buffer slots per output
	localparam int CREDIT_MAX = 4;
	localparam int CREDIT_W = 3;

	typedef logic [CREDIT_W-1:0] credit_t;

	// Credit count after reset, every slot free
	localparam credit_t CREDIT_FULL = credit_t'(CREDIT_MAX);

endpackage

// ==== rtl/sw_alloc_if.sv ====
`timescale 1ns/1ns

interface sw_alloc_if import router_pkg::*; ();

	// Input side, one entry per input port

	// Route held for the current packet
	logic req [NUM_PORTS];

	// Route held and a flit waiting in the buffer
	logic rdy [NUM_PORTS];

	// Next hop of the packet
	port_t dest [NUM_PORTS];

	// Next flit out is the tail
	logic last [NUM_PORTS];

	// Output side, one grant vector per output port
	// Bit i set means input i is read this cycle
	logic [NUM_PORTS-1:0] gnt [NUM_PORTS];

	modport requester (
		output req,
		output rdy,
		output dest,
		output last,
		input  gnt
	);

	modport allocator (
		input  req,
		input  rdy,
		input  dest,
		input  last,
		output gnt
	);

endinterface

// ==== run.sh ====
#!/bin/sh
# Build the router switch allocator testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
	--top-module tb_router_arbiter \
	-Mdir obj_dir \
	-f files.f

# Exit status of the simulation is the result
./obj_dir/Vtb_router_arbiter

// ==== verification/tb_clkgen.sv ====
`timescale 1ns/1ns

module tb_clkgen (
	output logic clk_o,
	output logic arst_n_o
);

	// 20 ns clock period
	localparam int HALF_PERIOD = 10;
	localparam int RESET_CYCLES = 8;

	initial begin
		clk_o = 1'b0;
		forever begin
			#HALF_PERIOD clk_o = ~clk_o;
		end
	end

	// Reset released on a falling edge, away from the sampling edge
	initial begin
		arst_n_o = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk_o);
		@(negedge clk_o);
		arst_n_o = 1'b1;
	end

endmodule

// ==== verification/tb_router_arbiter.sv ====
`timescale 1ns/1ns

module tb_router_arbiter import router_pkg::*; ();

	// Own router at y=2 and x=2
	localparam addr_t OWN_POS = 8'h22;

	// Packets per test are route 5, round robin 6, credit 2, parallel 5 and random
	localparam int RANDOM_PKTS = 40;
	localparam int TOTAL_FLITS = (5 + 6 + 2 + 5 + RANDOM_PKTS) * PKT_FLITS;
	localparam int TIMEOUT_CYCLES = TOTAL_FLITS * 10 + 200;
	localparam int CREDIT_DELAY = 2;

	logic                 clk;
	logic                 arst_n;
	addr_t                yx_pos = OWN_POS;
	logic [NUM_PORTS-1:0] empty = '1;
	addr_t                header_addr [NUM_PORTS] = '{default: '0};
	logic [NUM_PORTS-1:0] credit = '0;
	logic [NUM_PORTS-1:0] read;
	port_t                route [NUM_PORTS];
	port_t                mux_sel [NUM_PORTS];
	logic [NUM_PORTS-1:0] send;

	// Upstream buffers with one packet queue per input
	addr_t pkt_q [NUM_PORTS][$];
	int    flits_left [NUM_PORTS] = '{default: 0};
	int    exp_out [NUM_PORTS] = '{default: 0};
	int    fall_cycle [NUM_PORTS] = '{default: 0};
	int    first_lat [NUM_PORTS] = '{default: 0};
	int    read_cnt [NUM_PORTS] = '{default: 0};
	logic  random_gaps = 1'b0;

	// Downstream buffers and per-output packet tracking
	int    credit_due [NUM_PORTS][$];
	int    credits_given [NUM_PORTS] = '{default: CREDIT_MAX};
	int    send_cnt [NUM_PORTS] = '{default: 0};
	int    out_owner [NUM_PORTS] = '{default: -1};
	int    out_flits [NUM_PORTS] = '{default: 0};
	int    done_src [NUM_PORTS][$];
	logic  credit_auto = 1'b1;
	logic  random_credit = 1'b0;
	int    full_cycles = 0;

	int         cycle = 0;
	logic [7:0] lfsr_state = 8'd138;
	string      test_name = "setup";

	tb_clkgen clkgen_i (
		.clk_o    (clk),
		.arst_n_o (arst_n)
	);

	router_arbiter dut_i (
		.clk           (clk),
		.arst_n_i      (arst_n),
		.yx_pos_i      (yx_pos),
		.empty_i       (empty),
		.header_addr_i (header_addr),
		.credit_i      (credit),
		.read_o        (read),
		.route_o       (route),
		.mux_sel_o     (mux_sel),
		.send_o        (send)
	);

	task automatic stop_fail();
		$display("** FAIL **");
		$fatal(1);
	endtask

	task automatic check_value(input string what, input int exp, input int act);
		assert (act == exp) else begin
			$display("** Error [%s] %s: expected %0d, actual %0d",
				test_name, what, exp, act);
			stop_fail();
		end
	endtask

	task automatic check_true(input logic cond, input string msg);
		assert (cond) else begin
			$display("** Error [%s] %s", test_name, msg);
			stop_fail();
		end
	endtask

	// 8-bit Fibonacci LFSR with taps 8, 6, 5 and 4
	function automatic logic [7:0] lfsr_next(input logic [7:0] state);
		return {state[6:0], state[7] ^ state[5] ^ state[4] ^ state[3]};
	endfunction

	// One LFSR step per bit taken
	function automatic int rand_bits(input int n);
		int val;
		val = 0;
		for (int b = 0; b < n; b++) begin
			lfsr_state = lfsr_next(lfsr_state);
			val = (val << 1) | int'(lfsr_state[0]);
		end
		return val;
	endfunction

	function automatic addr_t make_addr(input int y, input int x);
		return addr_t'((y << COORD_W) | x);
	endfunction

	// Rows before columns and local when both match
	function automatic int yx_next_hop(input addr_t dest);
		int dy;
		int dx;
		dy = int'(dest[ADDR_W-1:COORD_W]) - int'(yx_pos[ADDR_W-1:COORD_W]);
		dx = int'(dest[COORD_W-1:0]) - int'(yx_pos[COORD_W-1:0]);
		if (dy != 0) begin
			return (dy > 0) ? int'(S) : int'(N);
		end
		if (dx != 0) begin
			return (dx > 0) ? int'(E) : int'(W);
		end
		return int'(L);
	endfunction

	// One destination per input and each on a different output
	function automatic addr_t spread_dest(input int src);
		case (src)
			0: return make_addr(2, 0);
			1: return make_addr(0, 5);
			2: return make_addr(9, 1);
			3: return make_addr(2, 2);
			default: return make_addr(2, 7);
		endcase
	endfunction

	function automatic logic model_idle();
		logic idle;
		idle = 1'b1;
		for (int p = 0; p < NUM_PORTS; p++) begin
			idle = idle && (pkt_q[p].size() == 0) && (flits_left[p] == 0);
			idle = idle && (out_owner[p] < 0) && (credit_due[p].size() == 0);
		end
		return idle;
	endfunction

	task automatic wait_idle();
		while (!model_idle()) begin
			@(negedge clk);
		end
		repeat (2) @(negedge clk);
	endtask

	// Upstream and downstream stimulus on the falling edge
	always @(negedge clk) begin
		logic stall;
		for (int i = 0; i < NUM_PORTS; i++) begin
			stall = random_gaps && (rand_bits(2) == 0);
			if (flits_left[i] == 0 && pkt_q[i].size() > 0 && !stall) begin
				header_addr[i] = pkt_q[i].pop_front();
				exp_out[i] = yx_next_hop(header_addr[i]);
				flits_left[i] = PKT_FLITS;
				if (empty[i]) begin
					fall_cycle[i] = cycle;
				end
			end
			empty[i] = (flits_left[i] == 0) || stall;
		end
		for (int o = 0; o < NUM_PORTS; o++) begin
			credit[o] = 1'b0;
			if (credit_due[o].size() > 0 && credit_due[o][0] <= cycle) begin
				void'(credit_due[o].pop_front());
				credit[o] = 1'b1;
			end
		end
	end

	// Flits consumed and forwarded at each rising edge
	always @(posedge clk) begin
		int src;
		int delay;
		for (int i = 0; i < NUM_PORTS; i++) begin
			if (read[i]) begin
				check_true(flits_left[i] > 0 && !empty[i],
					"input read while its buffer is empty");
				if (flits_left[i] == PKT_FLITS) begin
					first_lat[i] = cycle - fall_cycle[i];
				end
				flits_left[i]--;
				read_cnt[i]++;
			end
		end
		for (int o = 0; o < NUM_PORTS; o++) begin
			if (send[o]) begin
				src = int'(mux_sel[o]);
				check_true(read[src],
					"flit sent on an output without a read of its source");
				if (out_owner[o] < 0) begin
					check_value($sformatf("output of packet from input %0d", src),
						exp_out[src], o);
					check_value($sformatf("route_o[%0d]", src), exp_out[src],
						int'(route[src]));
					out_owner[o] = src;
				end
				check_value($sformatf("flit source on output %0d", o), out_owner[o], src);
				out_flits[o]++;
				send_cnt[o]++;
				check_true(send_cnt[o] <= credits_given[o],
					"output sent more flits than credits");
				if (credit_auto) begin
					delay = random_credit ? 1 + rand_bits(3) : CREDIT_DELAY;
					credit_due[o].push_back(cycle + delay);
				end
				if (out_flits[o] == PKT_FLITS) begin
					done_src[o].push_back(src);
					out_owner[o] = -1;
					out_flits[o] = 0;
				end
			end
			// A returned slot only covers sends from the next cycle on
			if (credit[o]) begin
				credits_given[o]++;
			end
		end
		if (send == '1) begin
			full_cycles++;
		end
		cycle++;
		assert (cycle <= TIMEOUT_CYCLES) else begin
			$display("** Error [%s] timeout, traffic did not drain in %0d cycles",
				test_name, TIMEOUT_CYCLES);
			stop_fail();
		end
	end

	task automatic check_reset_state();
		check_value("read_o", 0, int'(read));
		check_value("send_o", 0, int'(send));
		for (int p = 0; p < NUM_PORTS; p++) begin
			check_value($sformatf("route_o[%0d]", p), int'(N), int'(route[p]));
			check_value($sformatf("mux_sel_o[%0d]", p), int'(N), int'(mux_sel[p]));
		end
	endtask

	task automatic reset_test();
		test_name = "reset_test";
		while (arst_n !== 1'b1) begin
			@(negedge clk);
			check_reset_state();
		end
		repeat (2) @(negedge clk);
		check_reset_state();
	endtask

	task automatic route_test();
		port_t hops [NUM_PORTS] = '{W, N, S, L, E};
		int out;
		int base;
		test_name = "route_test";
		for (int i = 0; i < NUM_PORTS; i++) begin
			out = int'(hops[i]);
			base = send_cnt[out];
			pkt_q[i].push_back(spread_dest(i));
			wait_idle();
			check_value($sformatf("flits on output %0d", out), PKT_FLITS,
				send_cnt[out] - base);
			check_value($sformatf("mux_sel_o[%0d]", out), i, done_src[out][$]);
			check_value($sformatf("first read latency of input %0d", i), 2, first_lat[i]);
		end
	endtask

	task automatic round_robin_test();
		int order [6] = '{0, 2, 4, 0, 2, 4};
		addr_t east;
		test_name = "round_robin_test";
		east = make_addr(2, 9);
		done_src[int'(E)].delete();
		// Two packets each from N, W and L towards E
		for (int r = 0; r < 2; r++) begin
			pkt_q[int'(N)].push_back(east);
			pkt_q[int'(W)].push_back(east);
			pkt_q[int'(L)].push_back(east);
		end
		wait_idle();
		check_value("packets on output E", 6, done_src[int'(E)].size());
		for (int k = 0; k < 6; k++) begin
			check_value($sformatf("winner %0d on output E", k), order[k],
				done_src[int'(E)][k]);
		end
	endtask

	task automatic credit_test();
		int base_send;
		int base_read;
		test_name = "credit_test";
		credit_auto = 1'b0;
		base_send = send_cnt[int'(L)];
		base_read = read_cnt[int'(L)];
		pkt_q[int'(L)].push_back(make_addr(2, 2));
		pkt_q[int'(L)].push_back(make_addr(2, 2));
		while (send_cnt[int'(L)] - base_send < CREDIT_MAX) begin
			@(negedge clk);
		end
		repeat (6) @(negedge clk);
		check_value("flits sent on an empty credit", CREDIT_MAX,
			send_cnt[int'(L)] - base_send);
		check_value("reads on an empty credit", CREDIT_MAX,
			read_cnt[int'(L)] - base_read);
		// Each returned slot lets one flit through
		for (int k = 0; k < 2 * PKT_FLITS - CREDIT_MAX; k++) begin
			credit_due[int'(L)].push_back(cycle);
			repeat (4) @(negedge clk);
			check_value("flits after single credit", CREDIT_MAX + k + 1,
				send_cnt[int'(L)] - base_send);
		end
		// Downstream drains and hands every slot back
		for (int k = 0; k < CREDIT_MAX; k++) begin
			credit_due[int'(L)].push_back(cycle);
		end
		credit_auto = 1'b1;
		wait_idle();
	endtask

	task automatic parallel_test();
		test_name = "parallel_test";
		full_cycles = 0;
		for (int i = 0; i < NUM_PORTS; i++) begin
			pkt_q[i].push_back(spread_dest(i));
		end
		wait_idle();
		check_value("cycles with every output sending", PKT_FLITS, full_cycles);
	endtask

	task automatic random_test();
		int    exp_pkts [NUM_PORTS] = '{default: 0};
		int    base_done [NUM_PORTS];
		int    src;
		int    gap;
		addr_t dest;
		test_name = "random_test";
		for (int o = 0; o < NUM_PORTS; o++) begin
			base_done[o] = done_src[o].size();
		end
		random_gaps = 1'b1;
		random_credit = 1'b1;
		for (int p = 0; p < RANDOM_PKTS; p++) begin
			src = rand_bits(3) % NUM_PORTS;
			// Rows 1 to 4 around own row so every direction shows up
			dest = make_addr(rand_bits(2) + 1, rand_bits(4));
			exp_pkts[yx_next_hop(dest)]++;
			pkt_q[src].push_back(dest);
			gap = rand_bits(2);
			repeat (gap) @(negedge clk);
		end
		wait_idle();
		random_gaps = 1'b0;
		random_credit = 1'b0;
		for (int o = 0; o < NUM_PORTS; o++) begin
			check_value($sformatf("packets on output %0d", o), exp_pkts[o],
				done_src[o].size() - base_done[o]);
		end
	endtask

	initial begin
		reset_test();
		route_test();
		round_robin_test();
		credit_test();
		parallel_test();
		random_test();
		$display("** PASS **");
		$finish;
	end

endmodule
